//--- source/camera_pkg.sv
//==================================================
// Shared camera path definitions
// Sample, coordinate and packed word widths
// Raw sample, coordinate, RGB and packed pixel types
// Default line buffer depth and rate window
//==================================================

package camera_pkg;

  //==================================================
  // Widths
  //==================================================
  parameter int raw_width    = 12;  // Bits per raw camera sample
  parameter int coord_width  = 12;  // Column and row counters
  parameter int packed_width = 15;  // Display word, three 5-bit fields
  parameter int channel_msbs = 5;   // Top bits kept per channel

  //==================================================
  // Pixel types
  //==================================================
  typedef logic [raw_width-1:0]    raw_sample_t;
  typedef logic [coord_width-1:0]  coord_t;
  typedef logic [packed_width-1:0] packed_pixel_t;

  // Full precision demosaiced pixel
  typedef struct packed {
    raw_sample_t red;
    raw_sample_t green;
    raw_sample_t blue;
  } rgb_t;

  //==================================================
  // Default geometry and timing
  //==================================================
  parameter int default_line_width  = 1280;        // Widest sensor line, samples
  parameter int default_rate_window = 50_000_000;  // Rate window in pixel clocks

endpackage

//--- source/pixel_stream_if.sv
//==================================================
// Valid-strobed pixel stream interface
// Payload type set per instance, column and row
// Source and sink modports
//==================================================

`timescale 1ns/1ps

interface pixel_stream_if
  import camera_pkg::*;
#(
  parameter type payload_t = raw_sample_t  // Raw sample or RGB pixel
);

  logic     valid;    // One sample per high cycle, no stall
  payload_t payload;  // Sample or pixel value
  coord_t   col;      // Column of this sample
  coord_t   row;      // Row of this sample

  // Producer side
  modport source (output valid, output payload, output col, output row);

  // Consumer side
  modport sink (input valid, input payload, input col, input row);

endinterface

//--- source/ccd_capture.sv
//==================================================
// Camera capture front end
// Pin registers for data, frame and line valid
// Frame gating on the start level at frame start
// Column, row and frame counters
//==================================================

`timescale 1ns/1ps

module ccd_capture
  import camera_pkg::*;
(
  input  logic           ccd_pixel_clk,
  input  logic           rst,
  input  raw_sample_t    ccd_data,     // Raw sensor sample
  input  logic           ccd_fval,     // Frame valid pin
  input  logic           ccd_lval,     // Line valid pin
  input  logic           start,        // Capture request level
  pixel_stream_if.source raw_stream,   // Captured raw samples
  output logic           frame_done,   // End of a captured frame
  output logic [31:0]    frame_count   // Captured frames since reset
);

  raw_sample_t data_q;     // Registered pins
  logic        fval_q;
  logic        lval_q;
  logic        fval_d;     // One more stage for edge detection
  logic        lval_d;
  logic        capture_en; // Current frame is being captured
  logic        frame_active;
  logic        fval_rise;
  logic        fval_fall;
  logic        lval_fall;
  coord_t      col_cnt;
  coord_t      row_cnt;

  //==================================================
  // Pin sampling
  //==================================================
  always_ff @(posedge ccd_pixel_clk) begin
    data_q <= ccd_data;  // Raw sample from the sensor
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      fval_q <= 1'b0;
      lval_q <= 1'b0;
      fval_d <= 1'b0;
      lval_d <= 1'b0;
    end else begin
      fval_q <= ccd_fval;
      lval_q <= ccd_lval;
      fval_d <= fval_q;
      lval_d <= lval_q;
    end
  end

  assign fval_rise = fval_q && !fval_d;
  assign fval_fall = !fval_q && fval_d;
  assign lval_fall = !lval_q && lval_d;

  // Decision for the first sample uses start directly
  assign frame_active = fval_rise ? start : capture_en;

  //==================================================
  // Start/stop gating
  //==================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      capture_en <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      if (fval_rise) begin
        capture_en <= start;  // Start only looked at here
      end else if (fval_fall) begin
        capture_en <= 1'b0;
      end
      frame_done <= fval_fall && capture_en;  // Skipped frames give no pulse
    end
  end

  //==================================================
  // Counters
  //==================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      col_cnt     <= '0;
      row_cnt     <= '0;
      frame_count <= '0;
    end else begin
      if (fval_q && lval_q) begin
        col_cnt <= col_cnt + 1'b1;  // One step per sample in line
      end else if (lval_fall) begin
        col_cnt <= '0;
      end
      if (fval_rise) begin
        row_cnt <= '0;              // New frame starts at row 0
      end else if (lval_fall) begin
        row_cnt <= row_cnt + 1'b1;
      end
      frame_count <= frame_count + 32'(frame_done);
    end
  end

  //==================================================
  // Raw stream output
  //==================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      raw_stream.valid <= 1'b0;
    end else begin
      raw_stream.valid <= fval_q && lval_q && frame_active;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    raw_stream.payload <= data_q;
    raw_stream.col     <= col_cnt;
    raw_stream.row     <= fval_rise ? '0 : row_cnt;  // Counter clears a cycle late
  end

  // Samples only inside a frame whose start edge saw start high
  assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    raw_stream.valid |-> capture_en);

endmodule

//--- source/bayer_demosaic.sv
//==================================================
// Bayer to RGB conversion
// One-line buffer of red/green pairs from even rows
// One RGB pixel per 2x2 tile, half width and height
//==================================================

`timescale 1ns/1ps

module bayer_demosaic
  import camera_pkg::*;
#(
  parameter int line_width = default_line_width  // Widest line in samples
) (
  input  logic           ccd_pixel_clk,
  input  logic           rst,
  pixel_stream_if.sink   raw_stream,  // Raw Bayer samples
  pixel_stream_if.source rgb_stream   // One pixel per tile
);

  // Each buffer word holds both samples of an even row column pair
  localparam int pair_depth = (line_width + 1) / 2;
  localparam int addr_width = (pair_depth > 1) ? $clog2(pair_depth) : 1;

  typedef logic [addr_width-1:0] pair_addr_t;

  // Even row tile top: green at even column, red at odd column
  typedef struct packed {
    raw_sample_t green;
    raw_sample_t red;
  } bayer_pair_t;

  bayer_pair_t        line_buf [pair_depth];  // Upper row of the tiles
  bayer_pair_t        above_q;                // Tile top, read ahead
  raw_sample_t        prev_q;                 // Even column sample of this row
  pair_addr_t         pair_addr;
  logic               odd_row;
  logic               odd_col;
  logic               tile_end;               // Lower right sample of a tile
  logic [raw_width:0] green_sum;              // One guard bit
  rgb_t               pixel_d;

  assign pair_addr = pair_addr_t'(raw_stream.col >> 1);
  assign odd_row   = raw_stream.row[0];
  assign odd_col   = raw_stream.col[0];
  assign tile_end  = raw_stream.valid && odd_row && odd_col;

  //==================================================
  // Line buffer
  //==================================================
  // Green on even rows, blue on odd rows
  always_ff @(posedge ccd_pixel_clk) begin
    if (raw_stream.valid && !odd_col) begin
      prev_q <= raw_stream.payload;
    end
  end

  // Pair written once the red sample arrives
  always_ff @(posedge ccd_pixel_clk) begin
    if (raw_stream.valid && !odd_row && odd_col) begin
      line_buf[pair_addr] <= '{green: prev_q, red: raw_stream.payload};
    end
  end

  // Read on the blue sample, used on the next green
  always_ff @(posedge ccd_pixel_clk) begin
    if (raw_stream.valid && odd_row && !odd_col) begin
      above_q <= line_buf[pair_addr];
    end
  end

  //==================================================
  // Tile to pixel
  //==================================================
  assign green_sum = {1'b0, above_q.green} + {1'b0, raw_stream.payload};

  always_comb begin
    pixel_d.red   = above_q.red;
    pixel_d.green = green_sum[raw_width:1];  // Mean of both greens, rounded down
    pixel_d.blue  = prev_q;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      rgb_stream.valid <= 1'b0;
    end else begin
      rgb_stream.valid <= tile_end;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (tile_end) begin
      rgb_stream.payload <= pixel_d;
      rgb_stream.col     <= raw_stream.col >> 1;  // Half resolution
      rgb_stream.row     <= raw_stream.row >> 1;
    end
  end

  // Capture column must fit the buffer sized here
  assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    raw_stream.valid |-> (raw_stream.col < line_width));

endmodule

//--- source/pixel_packer.sv
//==================================================
// Display word packing
// Channel masking by enable bits
// Registered word, valid, column and row
//==================================================

`timescale 1ns/1ps

module pixel_packer
  import camera_pkg::*;
(
  input  logic          ccd_pixel_clk,
  input  logic          rst,
  pixel_stream_if.sink  rgb_stream,      // Demosaiced pixels
  input  logic [2:0]    channel_enable,  // Bit 2 red, 1 green, 0 blue
  output packed_pixel_t pixel_data,
  output logic          pixel_valid,
  output coord_t        pixel_col,
  output coord_t        pixel_row
);

  typedef logic [channel_msbs-1:0] field_t;

  rgb_t   pix;
  field_t red_f;
  field_t green_f;
  field_t blue_f;

  assign pix = rgb_stream.payload;

  // Top bits of each channel, zero when switched off
  assign red_f   = channel_enable[2] ? pix.red[raw_width-1 -: channel_msbs] : '0;
  assign green_f = channel_enable[1] ? pix.green[raw_width-1 -: channel_msbs] : '0;
  assign blue_f  = channel_enable[0] ? pix.blue[raw_width-1 -: channel_msbs] : '0;

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= rgb_stream.valid;
    end
  end

  // Spare top bit of the 16-bit FIFO word lies outside this word
  always_ff @(posedge ccd_pixel_clk) begin
    pixel_data <= {red_f, green_f, blue_f};
    pixel_col  <= rgb_stream.col;  // Kept aligned with the word
    pixel_row  <= rgb_stream.row;
  end

endmodule

//--- source/frame_rate_meter.sv
//==================================================
// Frame rate meter
// Window counter in pixel clocks
// Frames per window latched, tick toggled per window
//==================================================

`timescale 1ns/1ps

module frame_rate_meter #(
  parameter int rate_window = 50_000_000  // Window length in cycles
) (
  input  logic        ccd_pixel_clk,
  input  logic        rst,
  input  logic        frame_done,  // One pulse per captured frame
  output logic [31:0] frame_rate,  // Frames in the last full window
  output logic        rate_tick    // Inverts at each window end
);

  localparam int win_width = (rate_window > 1) ? $clog2(rate_window) : 1;

  logic [win_width-1:0] win_cnt;
  logic [31:0]          frames;   // Frames so far in this window
  logic                 win_end;

  assign win_end = (win_cnt == win_width'(rate_window - 1));

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      win_cnt    <= '0;
      frames     <= '0;
      frame_rate <= '0;
      rate_tick  <= 1'b0;
    end else if (win_end) begin
      win_cnt    <= '0;
      frame_rate <= frames;
      frames     <= 32'(frame_done);  // Coincident frame opens the new window
      rate_tick  <= ~rate_tick;
    end else begin
      win_cnt <= win_cnt + 1'b1;
      frames  <= frames + 32'(frame_done);
    end
  end

endmodule

//--- source/camera_pipeline_top.sv
//==================================================
// Camera acquisition path top level
// Capture, demosaic, packing and frame rate meter
// Plain ports, all on the pixel clock
//==================================================

`timescale 1ns/1ps

module camera_pipeline_top
  import camera_pkg::*;
#(
  parameter int line_width  = default_line_width,   // Line buffer depth
  parameter int rate_window = default_rate_window   // Rate window, cycles
) (
  input  logic          ccd_pixel_clk,
  input  logic          rst,
  // Camera pins
  input  raw_sample_t   ccd_data,
  input  logic          ccd_fval,
  input  logic          ccd_lval,
  // Controls
  input  logic          start,           // Capture on at frame start
  input  logic [2:0]    channel_enable,  // Red, green, blue masks
  // Packed pixel output
  output packed_pixel_t pixel_data,
  output logic          pixel_valid,
  output coord_t        pixel_col,
  output coord_t        pixel_row,
  // Frame statistics
  output logic [31:0]   frame_count,
  output logic [31:0]   frame_rate,
  output logic          rate_tick
);

  logic frame_done;  // Capture to rate meter

  pixel_stream_if #(.payload_t(raw_sample_t)) raw_stream ();
  pixel_stream_if #(.payload_t(rgb_t))        rgb_stream ();

  //==================================================
  // Stages
  //==================================================
  ccd_capture u_capture (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .ccd_data      (ccd_data),
    .ccd_fval      (ccd_fval),
    .ccd_lval      (ccd_lval),
    .start         (start),
    .raw_stream    (raw_stream.source),
    .frame_done    (frame_done),
    .frame_count   (frame_count)
  );

  bayer_demosaic #(.line_width(line_width)) u_demosaic (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .raw_stream    (raw_stream.sink),
    .rgb_stream    (rgb_stream.source)
  );

  pixel_packer u_packer (
    .ccd_pixel_clk  (ccd_pixel_clk),
    .rst            (rst),
    .rgb_stream     (rgb_stream.sink),
    .channel_enable (channel_enable),
    .pixel_data     (pixel_data),
    .pixel_valid    (pixel_valid),
    .pixel_col      (pixel_col),
    .pixel_row      (pixel_row)
  );

  frame_rate_meter #(.rate_window(rate_window)) u_rate (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .frame_done    (frame_done),
    .frame_rate    (frame_rate),
    .rate_tick     (rate_tick)
  );

endmodule

//--- verification/camera_pipeline_tb.sv
//==================================================
// Testbench for the camera acquisition path
// Camera model driven from the golden frame table
// Reference model of demosaic and packing
// Pixel, frame count and frame rate checks
//==================================================

`timescale 1ns/1ps

module camera_pipeline_tb
  import camera_pkg::*;
;

  localparam int tb_line_width  = 16;
  localparam int tb_rate_window = 600;
  localparam int max_frames     = 16;
  localparam int fields         = 7;  // Words per frame in the golden table

  typedef struct packed {
    coord_t        row;
    coord_t        col;
    packed_pixel_t data;
  } pixel_entry_t;

  logic          ccd_pixel_clk;
  logic          rst;
  raw_sample_t   ccd_data;
  logic          ccd_fval;
  logic          ccd_lval;
  logic          start;
  logic [2:0]    channel_enable;
  packed_pixel_t pixel_data;
  logic          pixel_valid;
  coord_t        pixel_col;
  coord_t        pixel_row;
  logic [31:0]   frame_count;
  logic [31:0]   frame_rate;
  logic          rate_tick;

  logic [31:0]  golden [0:fields*max_frames];  // Word 0 holds the frame count
  pixel_entry_t expected_q [$];
  pixel_entry_t exp_pixel;
  logic [31:0]  lfsr_state;
  int           value_errors;
  int           other_errors;
  int           pixels_seen;
  int           frame_pixels;
  logic [31:0]  frame_xor;
  logic         timed_out;
  logic         last_tick;
  logic [31:0]  count_at_tick;   // frame_count just before the last tick edge
  logic [31:0]  prev_count;      // frame_count one cycle earlier
  int           ticks_seen;
  int           num_frames;

  camera_pipeline_top #(
    .line_width  (tb_line_width),
    .rate_window (tb_rate_window)
  ) UUT (
    .ccd_pixel_clk  (ccd_pixel_clk),
    .rst            (rst),
    .ccd_data       (ccd_data),
    .ccd_fval       (ccd_fval),
    .ccd_lval       (ccd_lval),
    .start          (start),
    .channel_enable (channel_enable),
    .pixel_data     (pixel_data),
    .pixel_valid    (pixel_valid),
    .pixel_col      (pixel_col),
    .pixel_row      (pixel_row),
    .frame_count    (frame_count),
    .frame_rate     (frame_rate),
    .rate_tick      (rate_tick)
  );

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #2 ccd_pixel_clk = ~ccd_pixel_clk;  // 4 ns period
  end

  //==================================================
  // Helpers
  //==================================================
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      value_errors++;
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | lfsr_state[0];  // One step per bit
    end
  endtask

  // Test pattern, wraps at 12 bits
  function automatic int raw_sample(input int base, input int row, input int col);
    return (base + 16 * row + col) % 4096;
  endfunction

  // Top bits of a channel, zero when disabled
  function automatic logic [channel_msbs-1:0] top_field(input int value, input bit enable);
    return enable ? (value >> (raw_width - channel_msbs)) : '0;
  endfunction

  //==================================================
  // Reference model
  //==================================================
  task automatic predict_frame(input int width, input int height, input int mask,
                               input int base);
    int           red;
    int           green_a;
    int           green_b;
    int           blue;
    pixel_entry_t entry;
    for (int tr = 0; tr < height / 2; tr++) begin
      for (int tc = 0; tc < width / 2; tc++) begin
        red     = raw_sample(base, 2 * tr, 2 * tc + 1);      // Even row, odd column
        green_a = raw_sample(base, 2 * tr, 2 * tc);
        green_b = raw_sample(base, 2 * tr + 1, 2 * tc + 1);
        blue    = raw_sample(base, 2 * tr + 1, 2 * tc);      // Odd row, even column
        entry.data = {top_field(red, mask[2]),
                      top_field((green_a + green_b) / 2, mask[1]),
                      top_field(blue, mask[0])};
        entry.col  = coord_t'(tc);  // Half resolution
        entry.row  = coord_t'(tr);
        expected_q.push_back(entry);
      end
    end
  endtask

  //==================================================
  // Camera model
  //==================================================
  // Mode 0 start low, 1 start high, 2 start raised after line 0
  task automatic drive_frame(input int mode, input int width, input int height,
                             input int mask, input int base);
    int gap;
    start          = (mode == 1);
    channel_enable = mask[2:0];
    random_bits(5, gap);
    repeat (4 + gap) @(negedge ccd_pixel_clk);  // Gap between frames
    ccd_fval = 1'b1;
    random_bits(2, gap);
    repeat (1 + gap) @(negedge ccd_pixel_clk);
    for (int r = 0; r < height; r++) begin
      for (int c = 0; c < width; c++) begin
        ccd_lval = 1'b1;
        ccd_data = raw_sample_t'(raw_sample(base, r, c));
        @(negedge ccd_pixel_clk);
      end
      ccd_lval = 1'b0;
      if (mode == 2 && r == 0) start = 1'b1;  // Too late for this frame
      random_bits(3, gap);
      repeat (2 + gap) @(negedge ccd_pixel_clk);
    end
    ccd_fval = 1'b0;
    repeat (4) @(negedge ccd_pixel_clk);  // frame_done at +2, count at +3
  endtask

  task automatic wait_pipeline_empty();
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < 100) begin
      @(negedge ccd_pixel_clk);
      cycles++;
    end
    if (expected_q.size() != 0) begin
      $display("Timeout at %0t ns: %0d expected pixels never came out",
               $time, expected_q.size());
      other_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_rate_ticks(input int target);
    int cycles;
    cycles = 0;
    while (ticks_seen < target && cycles < 4 * tb_rate_window) begin
      @(negedge ccd_pixel_clk);
      cycles++;
    end
    if (ticks_seen < target) begin
      $display("Timeout at %0t ns: rate_tick toggled only %0d times", $time, ticks_seen);
      other_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_frame(input int index);
    int          mode;
    int          width;
    int          height;
    int          mask;
    int          base;
    logic [31:0] count_before;
    mode   = golden[1 + fields * index];
    width  = golden[2 + fields * index];
    height = golden[3 + fields * index];
    mask   = golden[4 + fields * index];
    base   = golden[5 + fields * index];
    if (mode == 1) predict_frame(width, height, mask, base);  // Only captured frames
    count_before = frame_count;
    frame_pixels = 0;
    frame_xor    = '0;
    drive_frame(mode, width, height, mask, base);
    check_value("frame_count", frame_count, count_before + (mode == 1));
    wait_pipeline_empty();
    check_value("frame pixel count", frame_pixels, golden[6 + fields * index]);
    check_value("frame pixel xor", frame_xor, golden[7 + fields * index]);
  endtask

  //==================================================
  // Output monitors
  //==================================================
  always @(negedge ccd_pixel_clk) begin
    if (!rst && pixel_valid) begin
      if (expected_q.size() == 0) begin
        $display("Error at %0t ns: pixel at col %0d row %0d when none was expected",
                 $time, pixel_col, pixel_row);
        other_errors++;
      end else begin
        exp_pixel = expected_q.pop_front();
        check_value("pixel_data", pixel_data, exp_pixel.data);
        check_value("pixel_col", pixel_col, exp_pixel.col);
        check_value("pixel_row", pixel_row, exp_pixel.row);
      end
      // Disabled channels must read zero
      if (!channel_enable[2]) check_value("pixel_data red field", pixel_data[14:10], 0);
      if (!channel_enable[1]) check_value("pixel_data green field", pixel_data[9:5], 0);
      if (!channel_enable[0]) check_value("pixel_data blue field", pixel_data[4:0], 0);
      pixels_seen++;
      frame_pixels++;
      frame_xor = frame_xor ^ pixel_data;
    end
  end

  // Frames between ticks, counted before each tick edge
  always @(negedge ccd_pixel_clk) begin
    if (rst) begin
      last_tick     = 1'b0;
      count_at_tick = '0;
      prev_count    = '0;
    end else begin
      if (rate_tick !== last_tick) begin
        check_value("frame_rate", frame_rate, prev_count - count_at_tick);
        count_at_tick = prev_count;
        last_tick     = rate_tick;
        ticks_seen++;
      end
      prev_count = frame_count;
    end
  end

  //==================================================
  // Main sequence
  //==================================================
  initial begin
    rst            = 1'b1;
    ccd_data       = '0;
    ccd_fval       = 1'b0;
    ccd_lval       = 1'b0;
    start          = 1'b0;
    channel_enable = 3'b111;
    lfsr_state     = 32'h5bf99fcc;
    value_errors   = 0;
    other_errors   = 0;
    pixels_seen    = 0;
    frame_pixels   = 0;
    frame_xor      = '0;
    timed_out      = 1'b0;
    ticks_seen     = 0;
    $readmemh("verification/capture_golden.txt", golden);

    repeat (4) begin
      @(negedge ccd_pixel_clk);
      check_value("pixel_valid in reset", pixel_valid, 0);
      check_value("frame_count in reset", frame_count, 0);
    end
    rst = 1'b0;
    @(negedge ccd_pixel_clk);
    check_value("pixel_valid after reset", pixel_valid, 0);
    check_value("frame_count after reset", frame_count, 0);
    check_value("frame_rate after reset", frame_rate, 0);
    check_value("rate_tick after reset", rate_tick, 0);

    num_frames = golden[0];
    if (golden[0] === 'x || num_frames < 1 || num_frames > max_frames) begin
      $display("Error: golden frame table missing or frame count out of range");
      other_errors++;
      num_frames = 0;
    end
    for (int f = 0; f < num_frames && !timed_out; f++) begin
      run_frame(f);
    end
    if (!timed_out) wait_rate_ticks(3);  // Window with frames, then idle windows

    $display("Summary: %0d frames, %0d pixels, %0d value mismatches, %0d other errors",
             num_frames, pixels_seen, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
source/camera_pkg.sv
source/pixel_stream_if.sv
source/ccd_capture.sv
source/bayer_demosaic.sv
source/pixel_packer.sv
source/frame_rate_meter.sv
source/camera_pipeline_top.sv
verification/camera_pipeline_tb.sv

//--- Bender.yml
package:
  name: camera_pipeline

sources:
  # Package and interface first, then stages, then top level
  - source/camera_pkg.sv
  - source/pixel_stream_if.sv
  - source/ccd_capture.sv
  - source/bayer_demosaic.sv
  - source/pixel_packer.sv
  - source/frame_rate_meter.sv
  - source/camera_pipeline_top.sv

  - target: simulation
    files:
      - verification/camera_pipeline_tb.sv

//--- verification/capture_golden.txt
// Columns, hex: start width height mask base pixels xor
// start 0 low, 1 high, 2 low at frame start and raised after line 0
// mask bit 2 red, bit 1 green, bit 0 blue; xor over all packed words
// Sample at row r, column c is (base + 16*r + c) mod 4096
// First value is the number of frame lines that follow
9
// Captured, red crosses a field step inside the first tile row
1 4  4 7 07D 4 0400
// Start low, no pixels
0 4  4 7 100 0 0000
// Green masked off
1 6  2 5 800 3 4010
// Start raised in the middle of the frame
2 4  4 7 200 0 0000
// Second row wraps to zero, green mean crosses a step
1 E  2 7 FF0 7 7E00
// Green only, six tiles
1 4  6 2 3F6 6 01E0
// Single tile, red masked off
1 2  2 3 ABC 1 02B5
// Full line buffer width, red only
1 10 2 4 07A 8 0400
// Capture resumes after skipped frames
1 4  2 7 000 2 0000
